// ==== verilog/aes_pkg.sv ====
// --------------------------------------------------------------------------
// AES-256 encryptor shared types, ring slot layout, round constants
// and the S-box and GF(2^8) byte helpers
// --------------------------------------------------------------------------
`default_nettype none

package aes_pkg;

    typedef logic [7:0]   byte_t;
    // byte 0 sits in bits 127:120, bytes run down each column in turn
    typedef logic [127:0] state_t;
    typedef logic [127:0] round_key_t;
    typedef logic [255:0] cipher_key_t;
    // round 0 is the initial key add, round 14 the last one
    typedef logic [3:0]   round_t;

    // one position of the round loop
    typedef struct packed {
        logic   valid;
        round_t round;
        state_t state;
    } loop_slot_t;

    localparam round_t LAST_ROUND     = 4'd14;
    localparam int     NUM_ROUND_KEYS = 15;

    typedef enum logic [1:0] {
        IDLE,
        EXPAND,
        READY
    } key_state_e;

    // indexed by word number / 8, entry 0 never used
    localparam logic [0:7][7:0] RCON = {
        8'h00, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40
    };

    // forward substitution table, one row per high nibble
    localparam logic [0:255][7:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic byte_t sbox(input byte_t b);
        return SBOX_TABLE[b];
    endfunction

    // multiply by x modulo the AES polynomial
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

`default_nettype wire

// ==== verilog/key_expander.sv ====
// --------------------------------------------------------------------------
// AES-256 key schedule, one round key per cycle into a 15-entry table
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module key_expander
    import aes_pkg::*;
(
    input  logic        OK_addRK,
    input  logic        resetn,
    input  logic        key_load,
    input  cipher_key_t key,
    input  round_t      rk_index,
    output round_key_t  round_key,
    output logic        key_ready
);

    key_state_e state;
    round_t     idx;
    round_key_t key_table [NUM_ROUND_KEYS];
    // the two round keys the next one is built from
    round_key_t prev_rk;
    round_key_t cur_rk;
    round_key_t next_rk;
    logic [31:0] temp_word;

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    function automatic logic [31:0] rot_word(input logic [31:0] w);
        return {w[23:0], w[31:24]};
    endfunction

    always_comb
    begin
        // even keys start a new 8-word group
        if (idx[0] == 1'b0)
            temp_word = sub_word(rot_word(cur_rk[31:0])) ^ {RCON[idx[3:1]], 24'h0};
        else
            temp_word = sub_word(cur_rk[31:0]);
        // each word chains off the one before it
        next_rk[127:96] = prev_rk[127:96] ^ temp_word;
        next_rk[95:64]  = prev_rk[95:64] ^ next_rk[127:96];
        next_rk[63:32]  = prev_rk[63:32] ^ next_rk[95:64];
        next_rk[31:0]   = prev_rk[31:0] ^ next_rk[63:32];
    end

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            state     <= IDLE;
            idx       <= '0;
            key_ready <= 1'b0;
        end
        else
        begin
            // ready one cycle after the table is complete
            key_ready <= (state == READY) && !key_load;
            if (key_load)
            begin
                state <= EXPAND;
                idx   <= 4'd2;
            end
            else if (state == EXPAND)
            begin
                idx <= idx + 4'd1;
                if (idx == LAST_ROUND)
                    state <= READY;
            end
        end
    end

    always_ff @(posedge OK_addRK)
    begin
        if (key_load)
        begin
            // keys 0 and 1 are the cipher key halves
            key_table[0] <= key[255:128];
            key_table[1] <= key[127:0];
            prev_rk      <= key[255:128];
            cur_rk       <= key[127:0];
        end
        else if (state == EXPAND)
        begin
            key_table[idx] <= next_rk;
            prev_rk        <= cur_rk;
            cur_rk         <= next_rk;
        end
    end

    // table read for the add-key stage
    assign round_key = key_table[rk_index];

endmodule

`default_nettype wire

// ==== verilog/block_ingress.sv ====
// --------------------------------------------------------------------------
// input queue with credit return, offers its head to the round loop
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module block_ingress
    import aes_pkg::*;
#(
    parameter int IN_DEPTH  = 2,
    parameter int OUT_DEPTH = 4
)
(
    input  logic       OK_addRK,
    input  logic       resetn,
    input  logic       in_valid,
    input  state_t     in_block,
    output logic       in_credit,
    input  logic       key_ready,
    input  logic       ins_take,
    input  logic       sent,
    output loop_slot_t ins_slot
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);
    localparam int OUT_W = $clog2(OUT_DEPTH + 1);

    state_t           queue [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    // blocks in the loop plus those waiting in egress
    logic [OUT_W-1:0] outstanding;
    logic             offer;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // hold back while egress could not absorb one more block
    assign offer    = (count != '0) && key_ready && (outstanding < OUT_W'(OUT_DEPTH));
    assign ins_slot = '{valid: offer, round: '0, state: queue[rd_ptr]};

    always_ff @(posedge OK_addRK)
    begin
        if (in_valid)
            queue[wr_ptr] <= in_block;
    end

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            outstanding <= '0;
            in_credit   <= 1'b0;
        end
        else
        begin
            if (in_valid)
                wr_ptr <= ptr_next(wr_ptr);
            if (ins_take)
                rd_ptr <= ptr_next(rd_ptr);
            count       <= count + CNT_W'(in_valid) - CNT_W'(ins_take);
            outstanding <= outstanding + OUT_W'(ins_take) - OUT_W'(sent);
            // one credit back per block entering the loop
            in_credit   <= ins_take;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sub_bytes_stage.sv ====
// --------------------------------------------------------------------------
// loop stage applying the S-box to every byte of the state
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sub_bytes_stage
    import aes_pkg::*;
(
    input  logic       OK_addRK,
    input  logic       resetn,
    input  loop_slot_t slot_in,
    output loop_slot_t slot_out
);

    byte_t [0:15] bytes_in;
    byte_t [0:15] subbed;
    logic         valid_q;
    round_t       round_q;
    state_t       state_q;

    assign bytes_in = slot_in.state;

    always_comb
    begin
        for (int i = 0; i < 16; i++)
            subbed[i] = sbox(bytes_in[i]);
    end

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
            valid_q <= 1'b0;
        else
            valid_q <= slot_in.valid;
    end

    // round number rides along untouched
    always_ff @(posedge OK_addRK)
    begin
        round_q <= slot_in.round;
        state_q <= subbed;
    end

    assign slot_out = '{valid: valid_q, round: round_q, state: state_q};

endmodule

`default_nettype wire

// ==== verilog/mix_stage.sv ====
// --------------------------------------------------------------------------
// loop stage doing ShiftRows, then MixColumns on all but the last round
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mix_stage
    import aes_pkg::*;
(
    input  logic       OK_addRK,
    input  logic       resetn,
    input  loop_slot_t slot_in,
    output loop_slot_t slot_out
);

    byte_t [0:15] bytes_in;
    byte_t [0:15] shifted;
    byte_t [0:15] mixed;
    logic         last_round;
    logic         valid_q;
    round_t       round_q;
    state_t       state_q;

    // one column times the fixed 02 03 01 01 matrix
    function automatic byte_t [0:3] mix_column(input byte_t [0:3] a);
        byte_t [0:3] r;
        r[0] = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
        r[1] = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
        r[2] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
        r[3] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
        return r;
    endfunction

    assign bytes_in = slot_in.state;
    // round field already holds the round being computed
    assign last_round = (slot_in.round == LAST_ROUND);

    always_comb
    begin
        // row r rotates left by r columns
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                shifted[c*4 + r] = bytes_in[((c + r) % 4) * 4 + r];
        for (int c = 0; c < 4; c++)
            mixed[c*4 +: 4] = mix_column(shifted[c*4 +: 4]);
    end

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
            valid_q <= 1'b0;
        else
            valid_q <= slot_in.valid;
    end

    always_ff @(posedge OK_addRK)
    begin
        round_q <= slot_in.round;
        // final round skips the column mix
        state_q <= last_round ? shifted : mixed;
    end

    assign slot_out = '{valid: valid_q, round: round_q, state: state_q};

endmodule

`default_nettype wire

// ==== verilog/add_key_stage.sv ====
// --------------------------------------------------------------------------
// loop stage adding the round key, inserting new blocks and retiring
// finished ones towards egress
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module add_key_stage
    import aes_pkg::*;
(
    input  logic       OK_addRK,
    input  logic       resetn,
    input  loop_slot_t slot_in,
    input  loop_slot_t ins_slot,
    output logic       ins_take,
    output round_t     rk_index,
    input  round_key_t round_key,
    output loop_slot_t slot_out,
    output logic       ret_valid,
    output state_t     ret_block
);

    loop_slot_t sel;
    state_t     keyed;
    logic       retire;
    logic       valid_q;
    round_t     round_q;
    state_t     state_q;

    // new blocks fill only an empty position
    assign ins_take = !slot_in.valid && ins_slot.valid;
    assign sel      = slot_in.valid ? slot_in : ins_slot;
    assign rk_index = sel.round;
    assign keyed    = sel.state ^ round_key;
    assign retire   = sel.valid && (sel.round == LAST_ROUND);

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            valid_q   <= 1'b0;
            ret_valid <= 1'b0;
        end
        else
        begin
            // a retiring block leaves its position empty
            valid_q   <= sel.valid && !retire;
            ret_valid <= retire;
        end
    end

    always_ff @(posedge OK_addRK)
    begin
        round_q   <= sel.round + 4'd1;
        state_q   <= keyed;
        ret_block <= keyed;
    end

    assign slot_out = '{valid: valid_q, round: round_q, state: state_q};

endmodule

`default_nettype wire

// ==== verilog/block_egress.sv ====
// --------------------------------------------------------------------------
// output FIFO sending finished blocks under an output credit counter
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module block_egress
    import aes_pkg::*;
#(
    parameter int OUT_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
)
(
    input  logic   OK_addRK,
    input  logic   resetn,
    input  logic   ret_valid,
    input  state_t ret_block,
    input  logic   out_credit,
    output logic   out_valid,
    output state_t out_block,
    output logic   sent
);

    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    state_t           fifo [OUT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credit_cnt;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(OUT_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // send the head whenever the sink has room
    assign out_valid = (count != '0) && (credit_cnt != '0);
    assign out_block = fifo[rd_ptr];
    assign sent      = out_valid;

    // ingress admission keeps this from ever overflowing
    always_ff @(posedge OK_addRK)
    begin
        if (ret_valid)
            fifo[wr_ptr] <= ret_block;
    end

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CRD_W'(OUT_CREDITS);
        end
        else
        begin
            if (ret_valid)
                wr_ptr <= ptr_next(wr_ptr);
            if (out_valid)
                rd_ptr <= ptr_next(rd_ptr);
            count      <= count + CNT_W'(ret_valid) - CNT_W'(out_valid);
            credit_cnt <= credit_cnt + CRD_W'(out_credit) - CRD_W'(out_valid);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/aes256_enc_top.sv ====
// --------------------------------------------------------------------------
// AES-256 encryptor, three-stage round loop between credit-based queues
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aes256_enc_top
    import aes_pkg::*;
#(
    parameter int IN_DEPTH    = 2,
    parameter int OUT_CREDITS = 2,
    parameter int OUT_DEPTH   = 4
)
(
    input  logic        OK_addRK,
    input  logic        resetn,
    input  logic        key_load,
    input  cipher_key_t key,
    output logic        key_ready,
    input  logic        in_valid,
    input  state_t      in_block,
    output logic        in_credit,
    output logic        out_valid,
    output state_t      out_block,
    input  logic        out_credit
);

    // loop links, named after the stage they leave
    loop_slot_t sub_slot;
    loop_slot_t mix_slot;
    loop_slot_t key_slot;
    loop_slot_t ins_slot;
    logic       ins_take;
    round_t     rk_index;
    round_key_t round_key;
    logic       ret_valid;
    state_t     ret_block;
    logic       sent;

    key_expander u_key_expander (
        .OK_addRK  (OK_addRK),
        .resetn    (resetn),
        .key_load  (key_load),
        .key       (key),
        .rk_index  (rk_index),
        .round_key (round_key),
        .key_ready (key_ready)
    );

    block_ingress #(
        .IN_DEPTH  (IN_DEPTH),
        .OUT_DEPTH (OUT_DEPTH)
    ) u_ingress (
        .OK_addRK  (OK_addRK),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_block  (in_block),
        .in_credit (in_credit),
        .key_ready (key_ready),
        .ins_take  (ins_take),
        .sent      (sent),
        .ins_slot  (ins_slot)
    );

    sub_bytes_stage u_sub_bytes (
        .OK_addRK (OK_addRK),
        .resetn   (resetn),
        .slot_in  (key_slot),
        .slot_out (sub_slot)
    );

    mix_stage u_mix (
        .OK_addRK (OK_addRK),
        .resetn   (resetn),
        .slot_in  (sub_slot),
        .slot_out (mix_slot)
    );

    // closes the loop back into sub bytes
    add_key_stage u_add_key (
        .OK_addRK  (OK_addRK),
        .resetn    (resetn),
        .slot_in   (mix_slot),
        .ins_slot  (ins_slot),
        .ins_take  (ins_take),
        .rk_index  (rk_index),
        .round_key (round_key),
        .slot_out  (key_slot),
        .ret_valid (ret_valid),
        .ret_block (ret_block)
    );

    block_egress #(
        .OUT_DEPTH   (OUT_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_egress (
        .OK_addRK   (OK_addRK),
        .resetn     (resetn),
        .ret_valid  (ret_valid),
        .ret_block  (ret_block),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_block  (out_block),
        .sent       (sent)
    );

endmodule

`default_nettype wire

// ==== bench/aes256_properties.sv ====
// --------------------------------------------------------------------------
// bound checks on the encryptor's credit paths and key-load timing
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aes256_properties
#(
    parameter int IN_DEPTH    = 2,
    parameter int OUT_CREDITS = 2,
    parameter int OUT_DEPTH   = 4,
    parameter int CNT_W       = $clog2(IN_DEPTH + 1),
    parameter int OUT_W       = $clog2(OUT_DEPTH + 1)
)
(
    input logic             OK_addRK,
    input logic             resetn,
    input logic             key_load,
    input logic             in_valid,
    input logic             in_credit,
    input logic             out_valid,
    input logic             out_credit,
    input logic [CNT_W-1:0] queue_count,
    input logic [OUT_W-1:0] outstanding
);

    // failure tally, scored per test by the testbench
    int violations = 0;
    // blocks taken in and credits handed back since reset
    int accepted;
    int credited;
    // sink space as seen from the credit wires alone
    int sink_space;

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            accepted   <= 0;
            credited   <= 0;
            sink_space <= OUT_CREDITS;
        end
        else
        begin
            accepted   <= accepted + (in_valid ? 1 : 0);
            credited   <= credited + (in_credit ? 1 : 0);
            sink_space <= sink_space + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
        end
    end

    // egress only sends into sink space
    out_needs_credit: assert property (@(posedge OK_addRK) disable iff (!resetn)
        out_valid |-> (sink_space > 0))
    else
    begin
        violations++;
        $error("out_valid raised with no output credit left");
    end

    // source must hold a credit for every block
    in_needs_room: assert property (@(posedge OK_addRK) disable iff (!resetn)
        in_valid |-> (queue_count < CNT_W'(IN_DEPTH)))
    else
    begin
        violations++;
        $error("in_valid raised while the ingress queue is full");
    end

    // new key only once the loop and egress are empty
    key_when_idle: assert property (@(posedge OK_addRK) disable iff (!resetn)
        key_load |-> (outstanding == '0))
    else
    begin
        violations++;
        $error("key_load raised while blocks are outstanding");
    end

    credits_bounded: assert property (@(posedge OK_addRK) disable iff (!resetn)
        credited <= accepted)
    else
    begin
        violations++;
        $error("more in_credit pulses than accepted blocks");
    end

endmodule

bind aes256_enc_top aes256_properties #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS),
    .OUT_DEPTH   (OUT_DEPTH)
) u_props (
    .OK_addRK    (OK_addRK),
    .resetn      (resetn),
    .key_load    (key_load),
    .in_valid    (in_valid),
    .in_credit   (in_credit),
    .out_valid   (out_valid),
    .out_credit  (out_credit),
    .queue_count (u_ingress.count),
    .outstanding (u_ingress.outstanding)
);

`default_nettype wire

// ==== bench/aes256_tb.sv ====
// --------------------------------------------------------------------------
// AES-256 encryptor testbench, known-answer vectors under credit flow
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aes256_tb
    import aes_pkg::*;
;

    localparam int IN_DEPTH    = 2;
    localparam int OUT_CREDITS = 2;
    localparam int OUT_DEPTH   = 4;
    // roughly five times the whole run
    localparam int CYCLE_LIMIT = 3000;

    // one plaintext with its known ciphertext
    typedef struct packed {
        state_t pt;
        state_t ct;
    } vector_t;

    // FIPS-197 C.3 and SP 800-38A F.1.5
    localparam cipher_key_t FIPS_KEY =
        256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
    localparam cipher_key_t SP_KEY =
        256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4;
    localparam vector_t FIPS_VEC = '{pt: 128'h00112233445566778899aabbccddeeff,
                                     ct: 128'h8ea2b7ca516745bfeafc49904b496089};
    localparam vector_t SP_VEC1  = '{pt: 128'h6bc1bee22e409f96e93d7e117393172a,
                                     ct: 128'hf3eed1bdb5d2a03c064b5a7e3db181f8};
    localparam vector_t SP_VEC2  = '{pt: 128'hae2d8a571e03ac9c9eb76fac45af8e51,
                                     ct: 128'h591ccb10d410ed26dc5ba74a31362870};

    logic        OK_addRK;
    logic        resetn;
    logic        key_load;
    cipher_key_t key;
    logic        key_ready;
    logic        in_valid;
    state_t      in_block;
    logic        in_credit;
    logic        out_valid;
    state_t      out_block;
    logic        out_credit = 1'b0;

    // expected ciphertexts in send order
    state_t      exp_q[$];
    // cycle at which each held sink credit goes back
    int          due_q[$];
    state_t      expected_block;
    int          cycles = 0;
    int          spent = 0;
    int          credits_back = 0;
    int          received = 0;
    int          errors = 0;
    int          sink_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          test_start_errors;
    logic        hold_credits = 1'b0;
    logic        rand_delays = 1'b0;
    logic [31:0] lfsr_state = 32'h9a88c160;
    int          rx_mark;
    int          cr_mark;

    aes256_enc_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS),
        .OUT_DEPTH   (OUT_DEPTH)
    ) DUT (
        .OK_addRK   (OK_addRK),
        .resetn     (resetn),
        .key_load   (key_load),
        .key        (key),
        .key_ready  (key_ready),
        .in_valid   (in_valid),
        .in_block   (in_block),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_block  (out_block),
        .out_credit (out_credit)
    );

    initial
    begin
        OK_addRK = 1'b0;
        forever #5 OK_addRK = ~OK_addRK;
    end

    // x^32 + x^22 + x^2 + x + 1, new bit shifted in at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic int total_errors();
        return errors + sink_errors + DUT.u_props.violations;
    endfunction

    // run limit
    always @(posedge OK_addRK)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    always @(posedge OK_addRK)
    begin
        if (in_credit)
            credits_back <= credits_back + 1;
    end

    // sink model, checks each block and returns its credit later
    always @(posedge OK_addRK)
    begin
        out_credit <= 1'b0;
        if (resetn)
        begin
            if (out_valid)
            begin
                received++;
                assert (exp_q.size() != 0)
                else
                begin
                    sink_errors++;
                    $display("output block at %0t with no block expected", $time);
                end
                if (exp_q.size() != 0)
                begin
                    expected_block = exp_q.pop_front();
                    assert (out_block == expected_block)
                    else
                    begin
                        sink_errors++;
                        $display("Error %0t: out_block %h, expected %h",
                                 $time, out_block, expected_block);
                    end
                end
                due_q.push_back(cycles + (rand_delays ? 1 + take_bits(3) : 1));
            end
            // credits pile up while held, then trickle back
            if (!hold_credits && due_q.size() != 0 && due_q[0] <= cycles)
            begin
                out_credit <= 1'b1;
                void'(due_q.pop_front());
            end
        end
    end

    // waits for a source credit, then drives one block
    task automatic send_one(input vector_t v);
        @(posedge OK_addRK);
        while (spent - credits_back >= IN_DEPTH)
        begin
            in_valid <= 1'b0;
            @(posedge OK_addRK);
        end
        in_valid <= 1'b1;
        in_block <= v.pt;
        exp_q.push_back(v.ct);
        spent++;
    endtask

    // kind 0 repeats the FIPS block, kind 1 alternates the two SP blocks
    task automatic send_blocks(input int n, input int kind);
        for (int i = 0; i < n; i++)
        begin
            if (kind == 0)
                send_one(FIPS_VEC);
            else
                send_one((i % 2 == 0) ? SP_VEC1 : SP_VEC2);
        end
        @(posedge OK_addRK);
        in_valid <= 1'b0;
    endtask

    task automatic drain_outputs();
        while (exp_q.size() != 0)
            @(posedge OK_addRK);
    endtask

    task automatic load_key(input cipher_key_t k);
        @(posedge OK_addRK);
        key_load <= 1'b1;
        key      <= k;
        @(posedge OK_addRK);
        key_load <= 1'b0;
        @(posedge OK_addRK);
        while (!key_ready)
            @(posedge OK_addRK);
    endtask

    task automatic value_check(input logic ok, input string what);
        assert (ok)
        else
        begin
            errors++;
            $display("Error %0t: %s", $time, what);
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (total_errors() == test_start_errors)
        begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: FAILED", num, name);
        end
        test_start_errors = total_errors();
    endtask

    initial
    begin
        resetn   <= 1'b0;
        key_load <= 1'b0;
        key      <= '0;
        in_valid <= 1'b0;
        in_block <= '0;
        test_start_errors = 0;
        repeat (4) @(posedge OK_addRK);
        resetn <= 1'b1;

        // reset values, then IN_DEPTH blocks sent on the initial credits
        @(posedge OK_addRK);
        value_check(!out_valid && !in_credit && !key_ready, "outputs not low after reset");
        send_blocks(IN_DEPTH, 0);
        repeat (10) @(posedge OK_addRK);
        value_check(credits_back == 0, "credit returned with no key");
        end_test(1, "reset and initial credits");

        // queued blocks start once the key is expanded
        load_key(FIPS_KEY);
        drain_outputs();
        end_test(2, "fips-197 c.3");

        load_key(SP_KEY);
        send_blocks(4, 1);
        drain_outputs();
        end_test(3, "sp 800-38a stream");

        hold_credits = 1'b1;
        rx_mark = received;
        send_blocks(6, 1);
        repeat (200) @(posedge OK_addRK);
        value_check(received - rx_mark <= OUT_CREDITS, "more outputs than output credits");
        cr_mark = credits_back;
        repeat (20) @(posedge OK_addRK);
        value_check(credits_back == cr_mark, "in_credit kept pulsing with buffers full");
        hold_credits = 1'b0;
        drain_outputs();
        value_check(received - rx_mark == 6, "wrong number of blocks after back-pressure");
        end_test(4, "output back-pressure");

        rand_delays = 1'b1;
        send_blocks(8, 1);
        drain_outputs();
        repeat (4) @(posedge OK_addRK);
        value_check(credits_back == spent, "in_credit pulses differ from accepted blocks");
        end_test(5, "random credit delays");

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/aes_pkg.sv
verilog/key_expander.sv
verilog/block_ingress.sv
verilog/sub_bytes_stage.sv
verilog/mix_stage.sv
verilog/add_key_stage.sv
verilog/block_egress.sv
verilog/aes256_enc_top.sv
bench/aes256_properties.sv
bench/aes256_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the AES-256 testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module aes256_tb \
    -f filelist.f -o aes256_sim

out=$(./obj_dir/aes256_sim +verilator+error+limit+1000 || true)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
